/* rtl/mv_pkg.sv */
// Dimensions, Q8.8 format and APB map of the matrix-vector unit.
// The row-group split assumes ROWS is a multiple of SLICE_ROWS, all powers of two.
package mv_pkg;

    localparam int ROWS       = 8;
    localparam int COLS       = 8;
    localparam int ELEM_W     = 16;
    localparam int FRAC_W     = 8;
    localparam int ACC_W      = 32;
    localparam int BLOCK_SIZE = 2;
    localparam int NUM_CORES  = 2;
    localparam int SLICE_ROWS = BLOCK_SIZE * NUM_CORES;
    localparam int NUM_GROUPS = ROWS / SLICE_ROWS;
    localparam int BEATS      = NUM_GROUPS * COLS;

    // Counter and index widths
    localparam int ROW_AW  = $clog2(ROWS);
    localparam int COL_AW  = $clog2(COLS);
    localparam int LANE_AW = $clog2(SLICE_ROWS);
    localparam int GRP_W   = $clog2(NUM_GROUPS);
    localparam int BEAT_CW = $clog2(BEATS + 1);

    // Signed 16-bit result range
    localparam int ELEM_MAX = 2 ** (ELEM_W - 1) - 1;
    localparam int ELEM_MIN = -(2 ** (ELEM_W - 1));

    typedef logic signed [ELEM_W-1:0] elem_t;
    // Column 0 in the low bits
    typedef elem_t [COLS-1:0] row_t;
    // Lane 0 is the lowest row of the group
    typedef elem_t [SLICE_ROWS-1:0] beat_t;

    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    localparam logic [APB_AW-1:0] ADDR_CTRL        = 8'h00;
    localparam logic [APB_AW-1:0] ADDR_STATUS      = 8'h04;
    localparam logic [APB_AW-1:0] ADDR_WEIGHT_BASE = 8'h40;
    localparam logic [APB_AW-1:0] ADDR_RESULT_BASE = 8'h80;

endpackage

/* rtl/ram_1w1r.sv */
`timescale 1ns/1ps
// One write port, one registered read port. Contents are undefined after reset.
// Reading an address in the cycle it is written returns the old word.
module ram_1w1r #(
    parameter type data_t = logic [7:0],
    parameter int  DEPTH  = 8
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  data_t                    wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output data_t                    rdata
);

    data_t mem_q [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem_q[waddr] <= wdata;
        end
        rdata <= mem_q[raddr];
    end

endmodule

/* rtl/row_buffer.sv */
`timescale 1ns/1ps
// Collects all rows of A, then streams one column of a row group per cycle.
// Group 0 is captured during the fill, later groups are prefetched behind the beats.
// start is only taken in IDLE.
module row_buffer (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  logic          row_valid,
    input  mv_pkg::row_t  row_data,
    output logic          row_ready,
    output logic          beat_valid,
    output mv_pkg::beat_t beat_data
);
    import mv_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        SLICE
    } state_e;

    state_e             state_q;
    logic [ROW_AW-1:0]  row_cnt_q;
    logic [BEAT_CW-1:0] beat_cnt_q;
    logic               beat_valid_q;
    beat_t              beat_q;
    row_t               bank_q [2][SLICE_ROWS];
    logic               pf_vld_q;
    logic [LANE_AW-1:0] pf_row_q;
    logic               pf_bank_q;

    logic               row_accept;
    logic               beat_issue;
    logic [COL_AW-1:0]  col;
    logic [GRP_W-1:0]   grp;
    logic               pf_req;
    logic [ROW_AW-1:0]  pf_addr;
    row_t               ram_rdata;

    assign row_ready  = (state_q == FILL);
    assign row_accept = row_valid && row_ready;
    assign beat_issue = (state_q == SLICE) && (beat_cnt_q < BEATS);
    assign col        = beat_cnt_q[COL_AW-1:0];
    assign grp        = beat_cnt_q[COL_AW +: GRP_W];

    // Fetch the next group's rows during the first beats of the current one
    assign pf_req  = beat_issue && (col < SLICE_ROWS) && (grp < NUM_GROUPS - 1);
    assign pf_addr = ROW_AW'((int'(grp) + 1) * SLICE_ROWS + int'(col));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            row_cnt_q    <= '0;
            beat_cnt_q   <= '0;
            beat_valid_q <= 1'b0;
            pf_vld_q     <= 1'b0;
            pf_row_q     <= '0;
            pf_bank_q    <= 1'b0;
        end else begin
            beat_valid_q <= beat_issue;
            pf_vld_q     <= pf_req;
            if (pf_req) begin
                pf_row_q  <= col[LANE_AW-1:0];
                pf_bank_q <= ~grp[0];
            end
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q   <= FILL;
                        row_cnt_q <= '0;
                    end
                end
                FILL: begin
                    if (row_accept) begin
                        row_cnt_q <= row_cnt_q + 1'b1;
                        if (row_cnt_q == ROW_AW'(ROWS - 1)) begin
                            state_q    <= SLICE;
                            beat_cnt_q <= '0;
                        end
                    end
                end
                SLICE: begin
                    // Stay one extra cycle so the last beat leaves inside SLICE
                    beat_cnt_q <= beat_cnt_q + 1'b1;
                    if (beat_cnt_q == BEAT_CW'(BEATS)) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Ping-pong group banks, transposed on the way out
    always_ff @(posedge clk) begin
        if (row_accept && (row_cnt_q < SLICE_ROWS)) begin
            bank_q[0][row_cnt_q[LANE_AW-1:0]] <= row_data;
        end
        if (pf_vld_q) begin
            bank_q[pf_bank_q][pf_row_q] <= ram_rdata;
        end
        if (beat_issue) begin
            for (int l = 0; l < SLICE_ROWS; l++) begin
                beat_q[l] <= bank_q[grp[0]][l][col];
            end
        end
    end

    assign beat_valid = beat_valid_q;
    assign beat_data  = beat_q;

    ram_1w1r #(
        .data_t (row_t),
        .DEPTH  (ROWS)
    ) i_row_ram (
        .clk   (clk),
        .we    (row_accept),
        .waddr (row_cnt_q),
        .wdata (row_data),
        .raddr (pf_addr),
        .rdata (ram_rdata)
    );

    // Input and output phases never overlap
    assert property (@(posedge clk) disable iff (!rst_n) !(row_ready && beat_valid));

    assert property (@(posedge clk) disable iff (!rst_n) beat_valid |-> state_q != IDLE);

endmodule

/* rtl/mac_stage.sv */
`timescale 1ns/1ps
// SLICE_ROWS lanes (NUM_CORES cores of BLOCK_SIZE lanes) of Q8.8 multiply-accumulate.
// Beats must arrive in column order 0..COLS-1 per group; the beat count sets the column.
// Results are saturated to 16 bits and drained one lane per cycle.
module mac_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  mv_pkg::row_t              weights,
    input  logic                      beat_valid,
    input  mv_pkg::beat_t             beat_data,
    output logic                      res_we,
    output logic [mv_pkg::ROW_AW-1:0] res_addr,
    output mv_pkg::elem_t             res_data,
    output logic                      group_written
);
    import mv_pkg::*;

    row_t                     w_q;
    logic [COL_AW-1:0]        col_q;
    logic [GRP_W-1:0]         grp_q;
    logic signed [ACC_W-1:0]  acc_q [SLICE_ROWS];
    elem_t                    hold_q [SLICE_ROWS];
    logic                     drain_q;
    logic [LANE_AW-1:0]       dcnt_q;
    logic [GRP_W-1:0]         dgrp_q;

    logic signed [2*ELEM_W-1:0] prod [SLICE_ROWS];
    logic signed [ACC_W-1:0]    sum [SLICE_ROWS];
    logic                       load_hold;
    logic                       drain_last;

    function automatic elem_t sat(input logic signed [ACC_W-1:0] v);
        if (v > ELEM_MAX) begin
            return elem_t'(ELEM_MAX);
        end else if (v < ELEM_MIN) begin
            return elem_t'(ELEM_MIN);
        end
        return v[ELEM_W-1:0];
    endfunction

    always_comb begin
        for (int l = 0; l < SLICE_ROWS; l++) begin
            prod[l] = $signed(beat_data[l]) * $signed(w_q[col_q]);
            sum[l]  = acc_q[l] + (prod[l] >>> FRAC_W);
        end
    end

    assign load_hold  = beat_valid && (col_q == COL_AW'(COLS - 1));
    assign drain_last = drain_q && (dcnt_q == LANE_AW'(SLICE_ROWS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_q   <= '0;
            grp_q   <= '0;
            drain_q <= 1'b0;
            dcnt_q  <= '0;
            dgrp_q  <= '0;
            for (int l = 0; l < SLICE_ROWS; l++) begin
                acc_q[l] <= '0;
            end
        end else begin
            if (start) begin
                col_q <= '0;
                grp_q <= '0;
                for (int l = 0; l < SLICE_ROWS; l++) begin
                    acc_q[l] <= '0;
                end
            end else if (beat_valid) begin
                col_q <= load_hold ? '0 : col_q + 1'b1;
                for (int l = 0; l < SLICE_ROWS; l++) begin
                    acc_q[l] <= load_hold ? '0 : sum[l];
                end
                if (load_hold) begin
                    grp_q <= (grp_q == GRP_W'(NUM_GROUPS - 1)) ? '0 : grp_q + 1'b1;
                end
            end

            // Drain of the previous group overlaps the next group's beats
            if (load_hold) begin
                drain_q <= 1'b1;
                dcnt_q  <= '0;
                dgrp_q  <= grp_q;
            end else if (drain_q) begin
                dcnt_q  <= dcnt_q + 1'b1;
                drain_q <= !drain_last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            w_q <= weights;
        end
        if (load_hold) begin
            for (int l = 0; l < SLICE_ROWS; l++) begin
                hold_q[l] <= sat(sum[l]);
            end
        end
    end

    assign res_we        = drain_q;
    assign res_addr      = ROW_AW'(int'(dgrp_q) * SLICE_ROWS + int'(dcnt_q));
    assign res_data      = hold_q[dcnt_q];
    assign group_written = drain_last;

    // Beat spacing from the row buffer must leave room for a full drain
    assert property (@(posedge clk) disable iff (!rst_n) load_hold |-> (!drain_q || drain_last));

endmodule

/* rtl/apb_regs.sv */
`timescale 1ns/1ps
// APB slave for control, status, weights and result readback.
// Weight and result reads are sign-extended; RESULT reads take one wait state.
// Decoding assumes both bases are aligned to their window size.
module apb_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [mv_pkg::APB_AW-1:0] paddr,
    input  logic [mv_pkg::APB_DW-1:0] pwdata,
    output logic [mv_pkg::APB_DW-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic                      start,
    output mv_pkg::row_t              weights,
    input  logic                      group_written,
    output logic [mv_pkg::ROW_AW-1:0] rd_addr,
    input  mv_pkg::elem_t             rd_data
);
    import mv_pkg::*;

    row_t              weights_q;
    logic              busy_q;
    logic              done_q;
    logic [GRP_W-1:0]  gcnt_q;
    logic              wait_q;

    logic              access;
    logic              aligned;
    logic              is_ctrl;
    logic              is_status;
    logic              is_weight;
    logic              is_result;
    logic              mapped;
    logic              wr_err;
    logic              wr_ok;
    logic              result_rd;
    logic [COL_AW-1:0] widx;

    assign access    = psel && penable;
    assign aligned   = (paddr[1:0] == 2'b00);
    assign is_ctrl   = (paddr == ADDR_CTRL);
    assign is_status = (paddr == ADDR_STATUS);
    assign is_weight = aligned && (paddr >= ADDR_WEIGHT_BASE)
                       && (paddr < ADDR_WEIGHT_BASE + 4 * COLS);
    assign is_result = aligned && (paddr >= ADDR_RESULT_BASE)
                       && (paddr < ADDR_RESULT_BASE + 4 * ROWS);
    assign mapped    = is_ctrl || is_status || is_weight || is_result;
    assign widx      = paddr[COL_AW+1:2];
    assign rd_addr   = paddr[ROW_AW+1:2];

    assign wr_err    = pwrite && (is_status || is_result || ((is_weight || is_ctrl) && busy_q));
    assign result_rd = access && is_result && !pwrite;

    // First RESULT access cycle lets the memory register the address
    assign pready  = !(result_rd && !wait_q);
    assign pslverr = access && pready && (!mapped || wr_err);
    assign wr_ok   = access && pwrite && mapped && !wr_err;
    assign start   = wr_ok && is_ctrl && pwdata[0];
    assign weights = weights_q;

    always_comb begin
        prdata = '0;
        if (is_status) begin
            prdata[1:0] = {done_q, busy_q};
        end else if (is_weight) begin
            prdata = APB_DW'(weights_q[widx]);
        end else if (is_result) begin
            prdata = APB_DW'(rd_data);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weights_q <= '0;
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            gcnt_q    <= '0;
            wait_q    <= 1'b0;
        end else begin
            wait_q <= result_rd && !wait_q;
            if (wr_ok && is_weight) begin
                weights_q[widx] <= pwdata[ELEM_W-1:0];
            end
            if (start) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
                gcnt_q <= '0;
            end else if (group_written) begin
                if (gcnt_q == GRP_W'(NUM_GROUPS - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                    gcnt_q <= '0;
                end else begin
                    gcnt_q <= gcnt_q + 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel);

    // Results only come back while a run is in progress
    assert property (@(posedge clk) disable iff (!rst_n) group_written |-> busy_q);

endmodule

/* rtl/mv_top.sv */
`timescale 1ns/1ps
// Matrix-vector unit y = A*w: rows of A on a valid/ready stream, w and y over APB.
// Load weights, write start, then stream all ROWS rows; poll STATUS for done.
module mv_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [mv_pkg::APB_AW-1:0] paddr,
    input  logic [mv_pkg::APB_DW-1:0] pwdata,
    output logic [mv_pkg::APB_DW-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  logic                      row_valid,
    input  mv_pkg::row_t              row_data,
    output logic                      row_ready
);
    import mv_pkg::*;

    logic              start;
    row_t              weights;
    logic              beat_valid;
    beat_t             beat_data;
    logic              res_we;
    logic [ROW_AW-1:0] res_addr;
    elem_t             res_data;
    logic              group_written;
    logic [ROW_AW-1:0] rd_addr;
    elem_t             rd_data;

    apb_regs i_apb_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .start         (start),
        .weights       (weights),
        .group_written (group_written),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    row_buffer i_row_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .row_valid  (row_valid),
        .row_data   (row_data),
        .row_ready  (row_ready),
        .beat_valid (beat_valid),
        .beat_data  (beat_data)
    );

    mac_stage i_mac_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .weights       (weights),
        .beat_valid    (beat_valid),
        .beat_data     (beat_data),
        .res_we        (res_we),
        .res_addr      (res_addr),
        .res_data      (res_data),
        .group_written (group_written)
    );

    ram_1w1r #(
        .data_t (elem_t),
        .DEPTH  (ROWS)
    ) i_result_ram (
        .clk   (clk),
        .we    (res_we),
        .waddr (res_addr),
        .wdata (res_data),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

endmodule

/* dv/tb_mv_top.sv */
`timescale 1ns/1ps
// Directed testbench for mv_top. Outputs are sampled on the falling clock edge.
// Expected results come from a Q8.8 model of y = A*w, with random data seeded once.
module tb_mv_top;
    import mv_pkg::*;

    localparam int APB_TIMEOUT = 16;
    localparam int ROW_TIMEOUT = 200;
    localparam int DONE_POLLS  = 200;

    logic              clk;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              row_valid;
    row_t              row_data;
    logic              row_ready;

    row_t mat [ROWS];
    row_t wvec;

    mv_top i_mv_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .row_valid (row_valid),
        .row_data  (row_data),
        .row_ready (row_ready)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED time %0t ns %s: got 0x%08h expected 0x%08h",
                                $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] sign_extend(input elem_t v);
        return {{16{v[15]}}, v};
    endfunction

    // Per-product shift, 32-bit sum, then clamp to the signed 16-bit range
    function automatic logic [31:0] model_result(input row_t a, input row_t w);
        int acc;
        int p;
        acc = 0;
        for (int c = 0; c < COLS; c++) begin
            p   = int'(a[c]) * int'(w[c]);
            acc = acc + (p >>> FRAC_W);
        end
        if (acc > 32767) begin
            acc = 32767;
        end else if (acc < -32768) begin
            acc = -32768;
        end
        return acc;
    endfunction

    // One wait state only for RESULT reads
    function automatic int expected_waits(input logic wr, input logic [7:0] addr);
        if (!wr && addr[1:0] == 2'b00 && addr >= ADDR_RESULT_BASE
            && addr < ADDR_RESULT_BASE + 4 * ROWS) begin
            return 1;
        end
        return 0;
    endfunction

    // Called at 1 ns after a rising edge, returns at the same phase
    task automatic bus_transfer(input logic wr, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int n;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready) begin
            n++;
            if (n > APB_TIMEOUT) begin
                abort_run($sformatf("APB transfer to 0x%02h never completed", addr));
            end
            @(negedge clk);
        end
        check_equal($sformatf("pready wait cycles at 0x%02h", addr), n,
                    expected_waits(wr, addr));
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        bus_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        bus_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check_equal($sformatf("pslverr on write to 0x%02h", addr), err, 0);
    endtask

    task automatic expect_reg(input string name, input logic [7:0] addr,
                              input logic [31:0] exp);
        logic [31:0] d;
        logic        err;
        apb_read(addr, d, err);
        check_equal({name, " pslverr"}, err, 0);
        check_equal(name, d, exp);
    endtask

    task automatic send_row(input row_t r);
        int n;
        row_valid = 1'b1;
        row_data  = r;
        n = 0;
        @(negedge clk);
        while (!row_ready) begin
            n++;
            if (n > ROW_TIMEOUT) begin
                abort_run("row_ready stayed low, a row was never accepted");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        row_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_done();
        logic [31:0] st;
        logic        err;
        int          n;
        n = 0;
        apb_read(ADDR_STATUS, st, err);
        while (!st[1]) begin
            n++;
            if (n > DONE_POLLS) begin
                abort_run("STATUS done bit never set after the last row");
            end
            apb_read(ADDR_STATUS, st, err);
        end
        check_equal("STATUS after done", st, 32'h2);
    endtask

    task automatic random_matrix();
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                mat[r][c] = 16'($urandom);
            end
        end
        for (int c = 0; c < COLS; c++) begin
            wvec[c] = 16'($urandom);
        end
    endtask

    // Loads weights, starts, streams all rows and waits for done
    task automatic run_matrix(input int gap_max, input bit check_busy);
        logic err;
        for (int c = 0; c < COLS; c++) begin
            write_reg(8'(ADDR_WEIGHT_BASE + 4 * c), {16'h0, wvec[c]});
        end
        write_reg(ADDR_CTRL, 32'h1);
        expect_reg("STATUS after start", ADDR_STATUS, 32'h1);
        if (check_busy) begin
            apb_write(ADDR_WEIGHT_BASE, 32'h0000_7777, err);
            check_equal("pslverr on weight write while busy", err, 1);
            expect_reg("weight 0 while busy", ADDR_WEIGHT_BASE, sign_extend(wvec[0]));
            apb_write(ADDR_CTRL, 32'h1, err);
            check_equal("pslverr on start while busy", err, 1);
        end
        for (int r = 0; r < ROWS; r++) begin
            send_row(mat[r]);
            if (gap_max > 0) begin
                idle_cycles($urandom_range(gap_max, 0));
            end
        end
        wait_done();
        check_equal("row_ready after done", row_ready, 0);
    endtask

    task automatic check_results();
        for (int r = 0; r < ROWS; r++) begin
            expect_reg($sformatf("y[%0d]", r), 8'(ADDR_RESULT_BASE + 4 * r),
                       model_result(mat[r], wvec));
        end
    endtask

    task automatic test_reset_state();
        check_equal("row_ready after reset", row_ready, 0);
        expect_reg("STATUS after reset", ADDR_STATUS, 32'h0);
        for (int c = 0; c < COLS; c++) begin
            expect_reg($sformatf("weight %0d after reset", c),
                       8'(ADDR_WEIGHT_BASE + 4 * c), 32'h0);
        end
    endtask

    task automatic test_register_access();
        logic [7:0]  bad_addr [6] = '{8'h08, 8'h3C, 8'h42, 8'h60, 8'hA0, 8'hFC};
        logic [31:0] d;
        logic        err;
        write_reg(8'(ADDR_WEIGHT_BASE + 12), 32'h0000_A5C3);
        expect_reg("weight 3", 8'(ADDR_WEIGHT_BASE + 12), 32'hFFFF_A5C3);
        write_reg(8'(ADDR_WEIGHT_BASE + 20), 32'h0000_1234);
        expect_reg("weight 5", 8'(ADDR_WEIGHT_BASE + 20), 32'h0000_1234);
        foreach (bad_addr[i]) begin
            apb_read(bad_addr[i], d, err);
            check_equal($sformatf("pslverr on read of 0x%02h", bad_addr[i]), err, 1);
        end
        apb_write(8'h10, 32'h1, err);
        check_equal("pslverr on unmapped write", err, 1);
        apb_write(ADDR_RESULT_BASE, 32'h55, err);
        check_equal("pslverr on RESULT write", err, 1);
        apb_write(ADDR_STATUS, 32'h3, err);
        check_equal("pslverr on STATUS write", err, 1);
        expect_reg("STATUS after bad writes", ADDR_STATUS, 32'h0);
    endtask

    task automatic test_identity();
        random_matrix();
        wvec    = '0;
        wvec[0] = 16'h0100;
        run_matrix(0, 1'b0);
        for (int r = 0; r < ROWS; r++) begin
            expect_reg($sformatf("identity y[%0d]", r), 8'(ADDR_RESULT_BASE + 4 * r),
                       sign_extend(mat[r][0]));
        end
    endtask

    task automatic test_random();
        random_matrix();
        // Rows 6 and 7 push every product to the positive or negative limit
        for (int c = 0; c < COLS; c++) begin
            mat[6][c] = wvec[c][15] ? 16'h8000 : 16'h7FFF;
            mat[7][c] = wvec[c][15] ? 16'h7FFF : 16'h8000;
        end
        run_matrix(0, 1'b0);
        check_results();
    endtask

    task automatic test_gaps_restart();
        random_matrix();
        run_matrix(5, 1'b1);
        check_results();
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        row_valid = 1'b0;
        row_data  = '0;
        void'($urandom(81));
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_register_access();
        test_identity();
        test_random();
        test_gaps_restart();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* sources.f */
rtl/mv_pkg.sv
rtl/ram_1w1r.sv
rtl/row_buffer.sv
rtl/mac_stage.sv
rtl/apb_regs.sv
rtl/mv_top.sv
dv/tb_mv_top.sv

/* Bender.yml */
package:
  name: mv_accel

sources:
  - files:
      - rtl/mv_pkg.sv
      - rtl/ram_1w1r.sv
      - rtl/row_buffer.sv
      - rtl/mac_stage.sv
      - rtl/apb_regs.sv
      - rtl/mv_top.sv
  - target: test
    files:
      - dv/tb_mv_top.sv
